//--- udp_echo_pkg.sv
package udp_echo_pkg;

    // UDP port answered by the echo service
    localparam logic [15:0] SERVICE_PORT = 16'd1234;

    // This node's IPv4 address, 192.168.1.128
    localparam logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // TTL written into every reply
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Queue sizes in entries
    localparam int HDR_FIFO_DEPTH = 4;
    localparam int PAYLOAD_FIFO_DEPTH = 256;

    // Parsed UDP header as delivered by the stack, 144 bits
    typedef struct packed {
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [7:0]  ttl;
    } udp_hdr_t;

    // One payload byte with its stream sideband
    typedef struct packed {
        logic [7:0] data;
        // Marks the final byte of a frame
        logic       last;
        // Error flag from the stack, carried along untouched
        logic       user;
    } axis_byte_t;

endpackage

//--- udp_port_filter.sv
module udp_port_filter (
    input  logic                    clk,
    input  logic                    rst,

    input  udp_echo_pkg::udp_hdr_t  in_hdr,
    input  logic                    in_hdr_valid,
    input  logic                    out_hdr_ready,
    output logic                    in_hdr_ready,

    input  udp_echo_pkg::axis_byte_t in_data,
    input  logic                    in_data_valid,
    input  logic                    out_data_ready,
    output logic                    in_data_ready,

    output udp_echo_pkg::udp_hdr_t  out_hdr,
    output logic                    out_hdr_valid,
    output udp_echo_pkg::axis_byte_t out_data,
    output logic                    out_data_valid
);

    import udp_echo_pkg::*;

    // A frame is open between its header and its last payload byte
    logic frame_open;
    // Decision for the open frame
    logic keep;

    logic port_match;
    logic hdr_fire;
    logic data_fire;
    logic hdr_slot_free;
    logic data_slot_free;

    assign port_match = (in_hdr.dest_port == SERVICE_PORT);

    // Output registers can take a new entry when empty or being emptied
    assign hdr_slot_free  = !out_hdr_valid || out_hdr_ready;
    assign data_slot_free = !out_data_valid || out_data_ready;

    // Only one header per frame, and only once the previous frame has ended
    assign in_hdr_ready = !frame_open && hdr_slot_free;

    // Dropped frames drain freely, kept ones wait for the output register
    assign in_data_ready = frame_open && (!keep || data_slot_free);

    assign hdr_fire  = in_hdr_valid && in_hdr_ready;
    assign data_fire = in_data_valid && in_data_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_open     <= 1'b0;
            keep           <= 1'b0;
            out_hdr_valid  <= 1'b0;
            out_data_valid <= 1'b0;
        end else begin
            if (out_hdr_valid && out_hdr_ready) begin
                out_hdr_valid <= 1'b0;
            end
            if (out_data_valid && out_data_ready) begin
                out_data_valid <= 1'b0;
            end

            if (hdr_fire) begin
                frame_open <= 1'b1;
                keep       <= port_match;
                if (port_match) begin
                    out_hdr_valid <= 1'b1;
                end
            end

            if (data_fire) begin
                if (keep) begin
                    out_data_valid <= 1'b1;
                end
                // Close the frame on its final byte
                if (in_data.last) begin
                    frame_open <= 1'b0;
                    keep       <= 1'b0;
                end
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (hdr_fire && port_match) begin
            out_hdr <= in_hdr;
        end
        if (data_fire && keep) begin
            out_data <= in_data;
        end
    end

endmodule

//--- stream_fifo.sv
module stream_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 4
) (
    input  logic   clk,
    input  logic   rst,

    input  entry_t in_entry,
    input  logic   in_valid,
    output logic   in_ready,

    output entry_t out_entry,
    output logic   out_valid,
    input  logic   out_ready
);

    entry_t mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    logic wr_en;
    logic rd_en;

    assign in_ready  = (count != DEPTH);
    assign out_valid = (count != 0);
    assign out_entry = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Pointer and occupancy tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                // Explicit wrap so any depth works, not just powers of two
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end

            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_entry;
        end
    end

endmodule

//--- udp_reply_builder.sv
module udp_reply_builder (
    input  logic                     clk,
    input  logic                     rst,

    // Request header and payload from the queues
    input  udp_echo_pkg::udp_hdr_t   q_hdr,
    input  logic                     q_hdr_valid,
    output logic                     q_hdr_ready,
    input  udp_echo_pkg::axis_byte_t q_data,
    input  logic                     q_data_valid,
    output logic                     q_data_ready,

    // Reply toward the UDP stack
    output udp_echo_pkg::udp_hdr_t   out_hdr,
    output logic                     out_hdr_valid,
    input  logic                     out_hdr_ready,
    output udp_echo_pkg::axis_byte_t out_data,
    output logic                     out_data_valid,
    input  logic                     out_data_ready
);

    import udp_echo_pkg::*;

    // Set once the reply header has left, cleared by the last payload byte
    logic reply_open;

    logic hdr_fire;
    logic data_fire;

    // Reply header derived from the request
    always_comb begin
        out_hdr.source_ip   = LOCAL_IP;
        out_hdr.dest_ip     = q_hdr.source_ip;
        // Ports swap so the reply returns to the sender's socket
        out_hdr.source_port = q_hdr.dest_port;
        out_hdr.dest_port   = q_hdr.source_port;
        out_hdr.length      = q_hdr.length;
        // Checksum zero means not computed for UDP over IPv4
        out_hdr.checksum    = '0;
        out_hdr.dscp        = '0;
        out_hdr.ecn         = '0;
        out_hdr.ttl         = REPLY_TTL;
    end

    // Header goes out only between replies
    assign out_hdr_valid = q_hdr_valid && !reply_open;
    assign q_hdr_ready   = out_hdr_ready && !reply_open;

    // Payload flows straight through once its header is gone
    assign out_data       = q_data;
    assign out_data_valid = q_data_valid && reply_open;
    assign q_data_ready   = out_data_ready && reply_open;

    assign hdr_fire  = out_hdr_valid && out_hdr_ready;
    assign data_fire = out_data_valid && out_data_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            reply_open <= 1'b0;
        end else if (hdr_fire) begin
            reply_open <= 1'b1;
        end else if (data_fire && q_data.last) begin
            reply_open <= 1'b0;
        end
    end

endmodule

//--- led_first_byte.sv
module led_first_byte (
    input  logic                     clk,
    input  logic                     rst,

    // Observed outgoing payload channel
    input  udp_echo_pkg::axis_byte_t beat,
    input  logic                     beat_valid,
    input  logic                     beat_ready,

    output logic [7:0]               led
);

    // High after the first byte of a frame until its last byte
    logic mid_frame;

    logic fire;

    assign fire = beat_valid && beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            mid_frame <= 1'b0;
            led       <= 8'h00;
        end else if (fire) begin
            if (!mid_frame) begin
                led <= beat.data;
            end
            mid_frame <= !beat.last;
        end
    end

endmodule

//--- udp_echo_core.sv
module udp_echo_core (
    input  logic                     clk,
    input  logic                     rst,

    input  udp_echo_pkg::udp_hdr_t   in_hdr,
    input  logic                     in_hdr_valid,
    output logic                     in_hdr_ready,
    input  udp_echo_pkg::axis_byte_t in_data,
    input  logic                     in_data_valid,
    output logic                     in_data_ready,

    output udp_echo_pkg::udp_hdr_t   out_hdr,
    output logic                     out_hdr_valid,
    input  logic                     out_hdr_ready,
    output udp_echo_pkg::axis_byte_t out_data,
    output logic                     out_data_valid,
    input  logic                     out_data_ready,

    output logic [7:0]               led
);

    import udp_echo_pkg::*;

    // Filter to queues
    udp_hdr_t   flt_hdr;
    logic       flt_hdr_valid;
    logic       flt_hdr_ready;
    axis_byte_t flt_data;
    logic       flt_data_valid;
    logic       flt_data_ready;

    // Queues to builder
    udp_hdr_t   q_hdr;
    logic       q_hdr_valid;
    logic       q_hdr_ready;
    axis_byte_t q_data;
    logic       q_data_valid;
    logic       q_data_ready;

    udp_port_filter port_filter (
        .clk            (clk),
        .rst            (rst),
        .in_hdr         (in_hdr),
        .in_hdr_valid   (in_hdr_valid),
        .out_hdr_ready  (flt_hdr_ready),
        .in_hdr_ready   (in_hdr_ready),
        .in_data        (in_data),
        .in_data_valid  (in_data_valid),
        .out_data_ready (flt_data_ready),
        .in_data_ready  (in_data_ready),
        .out_hdr        (flt_hdr),
        .out_hdr_valid  (flt_hdr_valid),
        .out_data       (flt_data),
        .out_data_valid (flt_data_valid)
    );

    // Headers queue separately so several frames can be in flight
    stream_fifo #(
        .entry_t (udp_hdr_t),
        .DEPTH   (HDR_FIFO_DEPTH)
    ) hdr_queue (
        .clk       (clk),
        .rst       (rst),
        .in_entry  (flt_hdr),
        .in_valid  (flt_hdr_valid),
        .in_ready  (flt_hdr_ready),
        .out_entry (q_hdr),
        .out_valid (q_hdr_valid),
        .out_ready (q_hdr_ready)
    );

    stream_fifo #(
        .entry_t (axis_byte_t),
        .DEPTH   (PAYLOAD_FIFO_DEPTH)
    ) payload_queue (
        .clk       (clk),
        .rst       (rst),
        .in_entry  (flt_data),
        .in_valid  (flt_data_valid),
        .in_ready  (flt_data_ready),
        .out_entry (q_data),
        .out_valid (q_data_valid),
        .out_ready (q_data_ready)
    );

    udp_reply_builder reply_builder (
        .clk            (clk),
        .rst            (rst),
        .q_hdr          (q_hdr),
        .q_hdr_valid    (q_hdr_valid),
        .q_hdr_ready    (q_hdr_ready),
        .q_data         (q_data),
        .q_data_valid   (q_data_valid),
        .q_data_ready   (q_data_ready),
        .out_hdr        (out_hdr),
        .out_hdr_valid  (out_hdr_valid),
        .out_hdr_ready  (out_hdr_ready),
        .out_data       (out_data),
        .out_data_valid (out_data_valid),
        .out_data_ready (out_data_ready)
    );

    led_first_byte led_latch (
        .clk        (clk),
        .rst        (rst),
        .beat       (out_data),
        .beat_valid (out_data_valid),
        .beat_ready (out_data_ready),
        .led        (led)
    );

endmodule

//--- udp_echo_props.sv
module udp_echo_props (
    input logic                     clk,
    input logic                     rst,
    input udp_echo_pkg::udp_hdr_t   out_hdr,
    input logic                     out_hdr_valid,
    input logic                     out_hdr_ready,
    input udp_echo_pkg::axis_byte_t out_data,
    input logic                     out_data_valid,
    input logic                     out_data_ready
);

    // Tracks whether the current reply header has already left
    logic hdr_sent;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_sent <= 1'b0;
        end else if (out_hdr_valid && out_hdr_ready) begin
            hdr_sent <= 1'b1;
        end else if (out_data_valid && out_data_ready && out_data.last) begin
            hdr_sent <= 1'b0;
        end
    end

    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_hdr))
        else $error("out_hdr dropped or changed while stalled");

    data_hold: assert property (@(posedge clk) disable iff (rst)
        out_data_valid && !out_data_ready |=> out_data_valid && $stable(out_data))
        else $error("out_data dropped or changed while stalled");

    data_after_hdr: assert property (@(posedge clk) disable iff (rst)
        out_data_valid |-> hdr_sent)
        else $error("payload presented before its reply header");

endmodule

//--- tb_udp_echo_core.sv
module tb_udp_echo_core;

    import udp_echo_pkg::*;

    logic       clk;
    logic       rst;
    udp_hdr_t   in_hdr;
    logic       in_hdr_valid;
    logic       in_hdr_ready;
    axis_byte_t in_data;
    logic       in_data_valid;
    logic       in_data_ready;
    udp_hdr_t   out_hdr;
    logic       out_hdr_valid;
    logic       out_hdr_ready;
    axis_byte_t out_data;
    logic       out_data_valid;
    logic       out_data_ready;
    logic [7:0] led;

    // Expected replies in output order, and the payload of the frame being sent
    udp_hdr_t   exp_hdr_q[$];
    axis_byte_t exp_byte_q[$];
    axis_byte_t tx_buf[$];

    int          hdr_errors;
    int          byte_errors;
    int          led_errors;
    int          flag_errors;
    int          other_errors;
    int          cycle_count;
    int          bytes_sent;
    logic        random_ready;
    logic [31:0] rand_state;

    udp_echo_core udp_echo_core_i (.*);

    bind udp_echo_core udp_echo_props props_i (
        .clk            (clk),
        .rst            (rst),
        .out_hdr        (out_hdr),
        .out_hdr_valid  (out_hdr_valid),
        .out_hdr_ready  (out_hdr_ready),
        .out_data       (out_data),
        .out_data_valid (out_data_valid),
        .out_data_ready (out_data_ready)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Subnet broadcast destination and nonzero checksum, TOS and TTL so every rewrite shows
    function automatic udp_hdr_t make_request(input logic [31:0] src_ip,
            input logic [15:0] src_port, input logic [15:0] dst_port, input int n);
        udp_hdr_t h;
        h.source_ip   = src_ip;
        h.dest_ip     = 32'hc0a801ff;
        h.source_port = src_port;
        h.dest_port   = dst_port;
        h.length      = 16'(8 + n);
        h.checksum    = 16'hbeef;
        h.dscp        = 6'd46;
        h.ecn         = 2'd1;
        h.ttl         = 8'd17;
        return h;
    endfunction

    function automatic udp_hdr_t expected_reply(input udp_hdr_t req);
        udp_hdr_t r;
        r.source_ip   = LOCAL_IP;
        r.dest_ip     = req.source_ip;
        r.source_port = req.dest_port;
        r.dest_port   = req.source_port;
        r.length      = req.length;
        r.checksum    = 16'h0000;
        r.dscp        = 6'd0;
        r.ecn         = 2'd0;
        r.ttl         = 8'd64;
        return r;
    endfunction

    task automatic check_hdr(input udp_hdr_t got, input udp_hdr_t exp, input string what);
        if (got !== exp) begin
            hdr_errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input axis_byte_t got, input axis_byte_t exp, input string what);
        if (got !== exp) begin
            byte_errors++;
            $display("mismatch at %0t: %s got data %h last %b user %b, expected %h %b %b",
                     $time, what, got.data, got.last, got.user, exp.data, exp.last, exp.user);
        end
    endtask

    task automatic check_led(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            led_errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic print_error_counts();
        $display("errors: header %0d, byte %0d, led %0d, flag %0d, other %0d",
                 hdr_errors, byte_errors, led_errors, flag_errors, other_errors);
    endtask

    // Whole limit scales with the payload actually pushed in
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 2000 + 50 * bytes_sent) begin
            other_errors++;
            $display("timeout: run stopped after %0d cycles waiting for the DUT", cycle_count);
            print_error_counts();
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic build_payload(input int n, input logic [7:0] start, input int user_at);
        axis_byte_t b;
        tx_buf.delete();
        for (int i = 0; i < n; i++) begin
            b.data = start + 8'(i * 37);
            b.last = (i == n - 1);
            b.user = (i == user_at);
            tx_buf.push_back(b);
        end
    endtask

    task automatic queue_expected(input udp_hdr_t req);
        exp_hdr_q.push_back(expected_reply(req));
        foreach (tx_buf[i]) begin
            exp_byte_q.push_back(tx_buf[i]);
        end
    endtask

    // Entered and left just after a rising edge
    task automatic send_frame(input udp_hdr_t hdr);
        in_hdr       = hdr;
        in_hdr_valid = 1'b1;
        @(negedge clk);
        while (!in_hdr_ready) @(negedge clk);
        @(posedge clk);
        #1;
        in_hdr_valid = 1'b0;
        foreach (tx_buf[i]) begin
            in_data       = tx_buf[i];
            in_data_valid = 1'b1;
            @(negedge clk);
            while (!in_data_ready) @(negedge clk);
            @(posedge clk);
            #1;
            bytes_sent++;
        end
        in_data_valid = 1'b0;
    endtask

    task automatic drive_ready();
        if (random_ready) begin
            rand_state     = next_random(rand_state);
            out_hdr_ready  = rand_state[23];
            out_data_ready = rand_state[29] | rand_state[17];
        end else begin
            out_hdr_ready  = 1'b1;
            out_data_ready = 1'b1;
        end
    endtask

    task automatic collect_reply();
        axis_byte_t exp_byte;
        logic [7:0] first_data;
        logic       seen_hdr;
        logic       seen_last;
        logic       first;
        seen_hdr = 1'b0;
        while (!seen_hdr) begin
            @(posedge clk);
            #1;
            drive_ready();
            @(negedge clk);
            if (out_hdr_valid && out_hdr_ready) begin
                seen_hdr = 1'b1;
                if (exp_hdr_q.size() == 0) begin
                    other_errors++;
                    $display("reply header at %0t with no reply expected", $time);
                end else begin
                    check_hdr(out_hdr, exp_hdr_q.pop_front(), "reply header");
                end
            end
        end
        seen_last  = 1'b0;
        first      = 1'b1;
        first_data = 8'h00;
        while (!seen_last) begin
            @(posedge clk);
            #1;
            drive_ready();
            @(negedge clk);
            if (out_data_valid && out_data_ready) begin
                if (exp_byte_q.size() == 0) begin
                    other_errors++;
                    $display("payload byte at %0t with no byte expected", $time);
                end else begin
                    exp_byte = exp_byte_q.pop_front();
                    if (first) begin
                        first_data = exp_byte.data;
                    end
                    check_byte(out_data, exp_byte, "reply byte");
                end
                first     = 1'b0;
                seen_last = out_data.last;
            end
        end
        @(posedge clk);
        #1;
        out_hdr_ready  = 1'b0;
        out_data_ready = 1'b0;
        check_led(led, first_data, "led after reply");
    endtask

    task automatic test_reset_state();
        check_flag(out_hdr_valid, 1'b0, "out_hdr_valid after reset");
        check_flag(out_data_valid, 1'b0, "out_data_valid after reset");
        check_led(led, 8'h00, "led after reset");
    endtask

    task automatic test_basic_echo();
        udp_hdr_t req;
        build_payload(5, 8'h41, -1);
        req = make_request(32'hc0a8010a, 16'd5000, SERVICE_PORT, 5);
        queue_expected(req);
        fork
            send_frame(req);
            collect_reply();
        join
    endtask

    task automatic test_drop_other_port();
        udp_hdr_t req;
        fork
            begin
                build_payload(6, 8'h10, -1);
                send_frame(make_request(32'hc0a80114, 16'd6000, SERVICE_PORT + 16'd1, 6));
                build_payload(4, 8'h90, -1);
                req = make_request(32'hc0a80115, 16'd6001, SERVICE_PORT, 4);
                queue_expected(req);
                send_frame(req);
            end
            collect_reply();
        join
        // Nothing of the dropped frame may surface later
        repeat (20) @(posedge clk);
        #1;
        check_flag(out_hdr_valid, 1'b0, "out_hdr_valid after dropped frame");
    endtask

    task automatic test_back_to_back_random();
        udp_hdr_t req;
        random_ready = 1'b1;
        fork
            for (int f = 0; f < 3; f++) begin
                build_payload(7 + 5 * f, 8'h20 + 8'(f * 16), -1);
                req = make_request(32'h0a000001 + f, 16'd7000 + 16'(f), SERVICE_PORT, 7 + 5 * f);
                queue_expected(req);
                send_frame(req);
            end
            repeat (3) collect_reply();
        join
        random_ready = 1'b0;
    endtask

    task automatic test_led_after_reply();
        logic [7:0] firsts [2] = '{8'ha5, 8'h3c};
        udp_hdr_t   req;
        for (int f = 0; f < 2; f++) begin
            build_payload(3, firsts[f], -1);
            req = make_request(32'hc0a80120, 16'd8000, SERVICE_PORT, 3);
            queue_expected(req);
            fork
                send_frame(req);
                collect_reply();
            join
            check_led(led, firsts[f], "led holds first byte");
        end
    endtask

    task automatic test_user_bit();
        udp_hdr_t req;
        build_payload(4, 8'h70, 2);
        req = make_request(32'hc0a80130, 16'd9000, SERVICE_PORT, 4);
        queue_expected(req);
        fork
            send_frame(req);
            collect_reply();
        join
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        in_hdr         = '0;
        in_hdr_valid   = 1'b0;
        in_data        = '0;
        in_data_valid  = 1'b0;
        out_hdr_ready  = 1'b0;
        out_data_ready = 1'b0;
        random_ready   = 1'b0;
        rand_state     = 32'ha827;
        hdr_errors     = 0;
        byte_errors    = 0;
        led_errors     = 0;
        flag_errors    = 0;
        other_errors   = 0;
        cycle_count    = 0;
        bytes_sent     = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_state();
        test_basic_echo();
        test_drop_other_port();
        test_back_to_back_random();
        test_led_after_reply();
        test_user_bit();

        if (exp_hdr_q.size() != 0 || exp_byte_q.size() != 0) begin
            other_errors++;
            $display("replies never arrived: %0d headers and %0d bytes still expected",
                     exp_hdr_q.size(), exp_byte_q.size());
        end
        print_error_counts();
        if (hdr_errors + byte_errors + led_errors + flag_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- udp_echo_core.f
udp_echo_pkg.sv
udp_port_filter.sv
stream_fifo.sv
udp_reply_builder.sv
led_first_byte.sv
udp_echo_core.sv
udp_echo_props.sv
tb_udp_echo_core.sv

//--- Bender.yml
package:
  name: udp_echo

sources:
  - udp_echo_pkg.sv
  - udp_port_filter.sv
  - stream_fifo.sv
  - udp_reply_builder.sv
  - led_first_byte.sv
  - udp_echo_core.sv
  - target: test
    files:
      - udp_echo_props.sv
      - tb_udp_echo_core.sv
